// File: Makefile
TOP := tb_graph_fetch

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: bench/clock_gen.sv
`default_nettype none

module clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic ap_clk,
  output logic control_areset
);

  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  // Reset held for a fixed number of cycles, released just after an edge
  initial begin
    control_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #1;
    control_areset = 1'b0;
  end

endmodule : clock_gen

`default_nettype wire

// File: bench/tb_graph_fetch.sv
`default_nettype none

module tb_graph_fetch import graph_types_pkg::*; import cache_types_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // All tests together take well under 2000 cycles
  localparam int          TIMEOUT_CYCLES  = 20000;
  localparam int          OUTSTANDING_MAX = 8;
  localparam int          SB_SIZE         = 64;
  localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

  logic          ap_clk;
  logic          control_areset;
  logic          desc_valid;
  graph_addr_t   desc_base_address;
  vertex_index_t desc_vertex_count;
  logic          cache_req_ready;
  logic          cache_resp_valid;
  logic          desc_ready;
  logic          busy;
  logic          cache_req_valid;
  cache_addr_t   cache_req_addr;

  // Scoreboard and bookkeeping
  bit            seen [SB_SIZE];
  graph_addr_t   exp_base;
  int            exp_count;
  int            xfer_count;
  int            resp_owed;
  bit            ready_random;
  bit            resp_enable;
  bit            hold_valid;
  cache_addr_t   hold_addr;
  logic [31:0]   lfsr_state = 32'd85575;
  string         cur_test = "reset";
  int            error_count;
  int            errors_at_start;
  int            test_count;
  int            tests_failed;
  int            cycle_count;

  clock_gen u_clock_gen (
    .ap_clk         (ap_clk),
    .control_areset (control_areset)
  );

  graph_fetch_top uut (
    .ap_clk            (ap_clk),
    .control_areset    (control_areset),
    .desc_valid        (desc_valid),
    .desc_base_address (desc_base_address),
    .desc_vertex_count (desc_vertex_count),
    .cache_req_ready   (cache_req_ready),
    .cache_resp_valid  (cache_resp_valid),
    .desc_ready        (desc_ready),
    .busy              (busy),
    .cache_req_valid   (cache_req_valid),
    .cache_req_addr    (cache_req_addr)
  );

  // --------------------
  // Helpers
  // --------------------

  // Galois LFSR stepped once per bit
  function automatic bit random_bit();
    bit lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) lfsr_state ^= LFSR_TAPS;
    return lsb;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("** Error: %s: %s expected %0h, actual %0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("Error in %s: %s", cur_test, msg);
  endtask

  // Mark one cache address in the bitmap
  task automatic record_transfer(input cache_addr_t addr);
    graph_addr_t offset;
    int          idx;
    offset = addr - exp_base;
    idx    = int'(offset / VERTEX_BYTES);
    if ((offset % VERTEX_BYTES) != 0 || offset / VERTEX_BYTES >= exp_count) begin
      report_failure($sformatf("address %h is outside the descriptor range", addr));
    end else if (seen[idx]) begin
      report_failure($sformatf("address %h was requested twice", addr));
    end else begin
      seen[idx] = 1'b1;
    end
    xfer_count++;
    resp_owed++;
  endtask

  // Outputs only move at the rising edge, so the falling edge sees them settled
  always @(negedge ap_clk) begin
    if (!control_areset) begin
      // Stalled request must hold valid and address
      if (hold_valid) begin
        check_value("stalled request", {1'b1, hold_addr}, {cache_req_valid, cache_req_addr});
      end
      if (cache_req_valid && cache_req_ready) record_transfer(cache_req_addr);
      hold_valid = cache_req_valid && !cache_req_ready;
      hold_addr  = cache_req_addr;
    end
  end

  // Ready pattern and responder driven just after the edge
  always @(posedge ap_clk) begin
    #1;
    cache_req_ready = ready_random ? random_bit() : 1'b1;
    if (resp_enable && resp_owed > 0 && random_bit()) begin
      cache_resp_valid = 1'b1;
      resp_owed--;
    end else begin
      cache_resp_valid = 1'b0;
    end
  end

  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = error_count;
    xfer_count      = 0;
    for (int i = 0; i < SB_SIZE; i++) seen[i] = 1'b0;
  endtask

  task automatic end_test();
    test_count++;
    if (error_count == errors_at_start) begin
      $display("test %s: PASS", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: FAIL, %0d errors", cur_test, error_count - errors_at_start);
    end
  endtask

  // Offer a descriptor and hold it until accepted
  task automatic send_descriptor(input graph_addr_t base, input vertex_index_t count);
    exp_base  = base;
    exp_count = int'(count);
    @(posedge ap_clk);
    #1;
    desc_valid        = 1'b1;
    desc_base_address = base;
    desc_vertex_count = count;
    @(negedge ap_clk);
    while (!desc_ready) @(negedge ap_clk);
    // Accepted on this edge
    @(posedge ap_clk);
    #1;
    desc_valid = 1'b0;
    @(negedge ap_clk);
    check_value("busy after accept", 1, busy);
    check_value("desc_ready after accept", 0, desc_ready);
  endtask

  // Wait for the end of the descriptor and for every response
  task automatic wait_idle();
    @(negedge ap_clk);
    while (busy) @(negedge ap_clk);
    check_value("desc_ready after busy", 1, desc_ready);
    while (resp_owed != 0) @(negedge ap_clk);
    @(negedge ap_clk);
  endtask

  task automatic check_set(input int count);
    int missing;
    missing = 0;
    for (int i = 0; i < count; i++) begin
      if (!seen[i]) missing++;
    end
    check_value("transfer count", count, xfer_count);
    check_value("missing vertices", 0, missing);
  endtask

  task automatic run_descriptor(input graph_addr_t base, input vertex_index_t count);
    send_descriptor(base, count);
    wait_idle();
    check_set(int'(count));
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset_state();
    begin_test("reset_state");
    @(negedge ap_clk);
    check_value("cache_req_valid", 0, cache_req_valid);
    check_value("busy", 0, busy);
    check_value("desc_ready", 1, desc_ready);
    end_test();
  endtask

  task automatic test_basic();
    begin_test("basic_count10");
    run_descriptor(32'h0000_1000, 16'd10);
    end_test();
  endtask

  task automatic test_random_ready();
    begin_test("random_ready_count37");
    ready_random = 1'b1;
    run_descriptor(32'h0002_0000, 16'd37);
    ready_random = 1'b0;
    end_test();
  endtask

  task automatic test_credit_limit();
    begin_test("credit_limit_count20");
    resp_enable = 1'b0;
    send_descriptor(32'h0000_8000, 16'd20);
    while (xfer_count < OUTSTANDING_MAX) @(negedge ap_clk);
    // Long enough for the FIFO to fill and engines to stall
    repeat (50) @(negedge ap_clk);
    check_value("transfers while withheld", OUTSTANDING_MAX, xfer_count);
    check_value("valid with no credit", 0, cache_req_valid);
    check_value("busy while withheld", 1, busy);
    resp_enable = 1'b1;
    wait_idle();
    check_set(20);
    end_test();
  endtask

  task automatic test_empty();
    begin_test("empty_count0");
    run_descriptor(32'h0000_4000, 16'd0);
    end_test();
  endtask

  task automatic test_short();
    begin_test("short_count3");
    run_descriptor(32'h0000_FFF0, 16'd3);
    end_test();
  endtask

  initial begin
    desc_valid        = 1'b0;
    desc_base_address = '0;
    desc_vertex_count = '0;
    cache_req_ready   = 1'b1;
    cache_resp_valid  = 1'b0;
    ready_random      = 1'b0;
    resp_enable       = 1'b1;
    hold_valid        = 1'b0;
    exp_base          = '0;
    exp_count         = 0;
    @(negedge ap_clk);
    while (control_areset) @(negedge ap_clk);
    test_reset_state();
    test_basic();
    test_random_ready();
    test_credit_limit();
    test_empty();
    test_short();
    $display("%0d tests run, %0d failed, %0d errors", test_count, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_graph_fetch

`default_nettype wire

// File: rtl/cache_request_generator.sv
`default_nettype none

module cache_request_generator
  import graph_types_pkg::*;
  import cache_types_pkg::*;
#(
  parameter int NUM_PE          = 4,
  parameter int FIFO_DEPTH      = 8,
  parameter int OUTSTANDING_MAX = 8
) (
  input  wire logic    ap_clk,
  input  wire logic    control_areset,
  input  wire logic    cache_req_ready,
  input  wire logic    cache_resp_valid,
  mem_req_if.generator mem_req [NUM_PE-1:0],
  output logic         cache_req_valid,
  output cache_addr_t  cache_req_addr,
  output logic         fifo_empty
);

  localparam int IDX_W = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

  // --------------------
  // Input stage
  // --------------------
  logic [NUM_PE-1:0] req_in;
  logic [NUM_PE-1:0] req_q;
  logic [NUM_PE-1:0] ack_q;
  logic [NUM_PE-1:0] pending;
  graph_addr_t       base_in   [NUM_PE];
  graph_addr_t       offset_in [NUM_PE];
  graph_addr_t       base_q    [NUM_PE];
  graph_addr_t       offset_q  [NUM_PE];

  for (genvar g = 0; g < NUM_PE; g++) begin : g_port
    assign req_in[g]      = mem_req[g].req;
    assign base_in[g]     = mem_req[g].base_address;
    assign offset_in[g]   = mem_req[g].address_offset;
    assign mem_req[g].ack = ack_q[g];
  end

  // Waiting and not yet acknowledged
  assign pending = req_q & ~ack_q;

  // --------------------
  // Round-robin select
  // --------------------
  logic [IDX_W-1:0] last_grant;
  logic [IDX_W-1:0] grant_idx;
  logic             grant_valid;
  logic             grant_ok;
  logic             fifo_wr_en;
  cache_addr_t      fifo_wr_data;
  logic             fifo_full;

  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx   = last_grant;
    // Search starts one past the last winner
    for (int k = 1; k <= NUM_PE; k++) begin
      cand = (int'(last_grant) + k) % NUM_PE;
      if (!grant_valid && pending[cand]) begin
        grant_valid = 1'b1;
        grant_idx   = IDX_W'(cand);
      end
    end
  end

  // Skip a cycle after each write so full is never stale
  assign grant_ok = grant_valid && !fifo_full && !fifo_wr_en;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      req_q      <= '0;
      ack_q      <= '0;
      fifo_wr_en <= 1'b0;
      last_grant <= IDX_W'(NUM_PE - 1);
    end else begin
      req_q      <= req_in;
      fifo_wr_en <= grant_ok;
      // Ack falls once the engine has dropped req
      for (int i = 0; i < NUM_PE; i++) begin
        if (!req_q[i]) ack_q[i] <= 1'b0;
      end
      // Ack rises with the FIFO write
      if (grant_ok) begin
        ack_q[grant_idx] <= 1'b1;
        last_grant       <= grant_idx;
      end
    end
  end

  // Payload path, base plus offset
  always_ff @(posedge ap_clk) begin
    base_q       <= base_in;
    offset_q     <= offset_in;
    fifo_wr_data <= cache_addr_t'(base_q[grant_idx] + offset_q[grant_idx]);
  end

  // --------------------
  // FIFO and credits
  // --------------------
  credit_count_t credits;
  logic          credit_ok;
  logic          fifo_rd_valid;
  logic          xfer;

  assign credit_ok       = (credits != '0);
  assign cache_req_valid = fifo_rd_valid && credit_ok;
  assign xfer            = cache_req_valid && cache_req_ready;

  request_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_request_fifo (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .wr_en          (fifo_wr_en),
    .wr_data        (fifo_wr_data),
    .rd_ready       (cache_req_ready && credit_ok),
    .full           (fifo_full),
    .empty          (fifo_empty),
    .rd_valid       (fifo_rd_valid),
    .rd_data        (cache_req_addr)
  );

  // Transfer takes a credit, response gives one back
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      credits <= credit_count_t'(OUTSTANDING_MAX);
    end else begin
      case ({xfer, cache_resp_valid})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule : cache_request_generator

`default_nettype wire

// File: rtl/cache_types_pkg.sv
`default_nettype none

package cache_types_pkg;

  // --------------------
  // Cache side
  // --------------------

  // Address as issued to the cache
  typedef logic [31:0] cache_addr_t;

  // Credit counter width, room for 16 in flight
  localparam int CREDIT_WIDTH = 5;

  // Outstanding-request credit count
  typedef logic [CREDIT_WIDTH-1:0] credit_count_t;

endpackage : cache_types_pkg

`default_nettype wire

// File: rtl/descriptor_dispatcher.sv
`default_nettype none

module descriptor_dispatcher import graph_types_pkg::*; #(
  parameter int NUM_PE = 4
) (
  input  wire logic              ap_clk,
  input  wire logic              control_areset,
  input  wire logic              desc_valid,
  input  wire graph_addr_t       desc_base_address,
  input  wire vertex_index_t     desc_vertex_count,
  input  wire logic [NUM_PE-1:0] pe_done,
  input  wire logic              fifo_empty,
  output logic                   desc_ready,
  output logic                   busy,
  output logic                   start,
  output graph_descriptor_t      descriptor
);

  // --------------------
  // Controller state
  // --------------------
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STARTING,
    ST_RUNNING
  } disp_state_t;

  disp_state_t state;

  // Accept only while idle
  assign desc_ready = (state == ST_IDLE);
  assign busy       = (state != ST_IDLE);

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state <= ST_IDLE;
      start <= 1'b0;
    end else begin
      // Start is a single-cycle pulse
      start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (desc_valid) begin
            state <= ST_STARTING;
          end
        end
        ST_STARTING: begin
          start <= 1'b1;
          state <= ST_RUNNING;
        end
        ST_RUNNING: begin
          // Engines still show done while start is in flight
          if (!start && (&pe_done) && fifo_empty) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Descriptor held until the next acceptance
  always_ff @(posedge ap_clk) begin
    if (desc_valid && desc_ready) begin
      descriptor.base_address <= desc_base_address;
      descriptor.vertex_count <= desc_vertex_count;
    end
  end

endmodule : descriptor_dispatcher

`default_nettype wire

// File: rtl/graph_fetch_top.sv
`default_nettype none

module graph_fetch_top
  import graph_types_pkg::*;
  import cache_types_pkg::*;
#(
  parameter int NUM_PE          = 4,
  parameter int FIFO_DEPTH      = 8,
  parameter int OUTSTANDING_MAX = 8
) (
  input  wire logic          ap_clk,
  input  wire logic          control_areset,
  input  wire logic          desc_valid,
  input  wire graph_addr_t   desc_base_address,
  input  wire vertex_index_t desc_vertex_count,
  input  wire logic          cache_req_ready,
  input  wire logic          cache_resp_valid,
  output logic               desc_ready,
  output logic               busy,
  output logic               cache_req_valid,
  output cache_addr_t        cache_req_addr
);

  // --------------------
  // Internal wiring
  // --------------------
  logic              start;
  graph_descriptor_t descriptor;
  logic [NUM_PE-1:0] pe_done;
  logic              fifo_empty;

  // One handshake channel per engine
  mem_req_if mem_req [NUM_PE-1:0] ();

  descriptor_dispatcher #(
    .NUM_PE (NUM_PE)
  ) u_dispatcher (
    .ap_clk            (ap_clk),
    .control_areset    (control_areset),
    .desc_valid        (desc_valid),
    .desc_base_address (desc_base_address),
    .desc_vertex_count (desc_vertex_count),
    .pe_done           (pe_done),
    .fifo_empty        (fifo_empty),
    .desc_ready        (desc_ready),
    .busy              (busy),
    .start             (start),
    .descriptor        (descriptor)
  );

  // Engine g walks vertices g, g+NUM_PE, ...
  for (genvar g = 0; g < NUM_PE; g++) begin : g_engine
    vertex_request_engine #(
      .NUM_PE   (NUM_PE),
      .PE_INDEX (g)
    ) u_engine (
      .ap_clk         (ap_clk),
      .control_areset (control_areset),
      .start          (start),
      .descriptor     (descriptor),
      .done           (pe_done[g]),
      .mem_req        (mem_req[g])
    );
  end

  cache_request_generator #(
    .NUM_PE          (NUM_PE),
    .FIFO_DEPTH      (FIFO_DEPTH),
    .OUTSTANDING_MAX (OUTSTANDING_MAX)
  ) u_generator (
    .ap_clk           (ap_clk),
    .control_areset   (control_areset),
    .cache_req_ready  (cache_req_ready),
    .cache_resp_valid (cache_resp_valid),
    .mem_req          (mem_req),
    .cache_req_valid  (cache_req_valid),
    .cache_req_addr   (cache_req_addr),
    .fifo_empty       (fifo_empty)
  );

endmodule : graph_fetch_top

`default_nettype wire

// File: rtl/graph_types_pkg.sv
`default_nettype none

package graph_types_pkg;

  // --------------------
  // Vertex addressing
  // --------------------

  // Vertex number within one descriptor
  typedef logic [15:0] vertex_index_t;

  // Byte address on the graph memory side
  typedef logic [31:0] graph_addr_t;

  // Work descriptor, base first then count
  typedef struct packed {
    graph_addr_t   base_address;
    vertex_index_t vertex_count;
  } graph_descriptor_t;

  // Size of one vertex record in bytes
  localparam int VERTEX_BYTES = 4;

endpackage : graph_types_pkg

`default_nettype wire

// File: rtl/mem_req_if.sv
`default_nettype none

interface mem_req_if import graph_types_pkg::*; ();

  // Four-phase request, engine to generator
  logic        req;
  logic        ack;
  // Payload, stable while req is high
  graph_addr_t base_address;
  graph_addr_t address_offset;

  modport engine (
    output req, base_address, address_offset,
    input  ack
  );

  modport generator (
    input  req, base_address, address_offset,
    output ack
  );

endinterface : mem_req_if

`default_nettype wire

// File: rtl/request_fifo.sv
`default_nettype none

module request_fifo import cache_types_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  wire logic        ap_clk,
  input  wire logic        control_areset,
  input  wire logic        wr_en,
  input  wire cache_addr_t wr_data,
  input  wire logic        rd_ready,
  output logic             full,
  output logic             empty,
  output logic             rd_valid,
  output cache_addr_t      rd_data
);

  localparam int AW = $clog2(DEPTH);

  // Storage
  cache_addr_t mem [DEPTH];

  // Pointers carry a wrap bit above the index
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_write;
  logic        do_read;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_write = wr_en && !full;
  assign do_read  = rd_ready && !empty;

  // Head shown without a read cycle
  assign rd_valid = !empty;
  assign rd_data  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

endmodule : request_fifo

`default_nettype wire

// File: rtl/vertex_request_engine.sv
`default_nettype none

module vertex_request_engine import graph_types_pkg::*; #(
  parameter int NUM_PE   = 4,
  parameter int PE_INDEX = 0
) (
  input  wire logic              ap_clk,
  input  wire logic              control_areset,
  input  wire logic              start,
  input  wire graph_descriptor_t descriptor,
  output logic                   done,
  mem_req_if.engine              mem_req
);

  // --------------------
  // Handshake FSM
  // --------------------
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RELEASE
  } eng_state_t;

  eng_state_t    state;
  vertex_index_t vertex;
  // One extra bit so the stride cannot wrap
  logic [16:0]   next_vertex;

  assign next_vertex  = {1'b0, vertex} + 17'(NUM_PE);

  // Request payload follows the current vertex
  assign mem_req.req            = (state == ST_REQ);
  assign mem_req.base_address   = descriptor.base_address;
  assign mem_req.address_offset = graph_addr_t'(vertex) * graph_addr_t'(VERTEX_BYTES);

  assign done = (state == ST_IDLE);

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state  <= ST_IDLE;
      vertex <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Engines beyond the count stay idle
          if (start && (17'(PE_INDEX) < {1'b0, descriptor.vertex_count})) begin
            vertex <= vertex_index_t'(PE_INDEX);
            state  <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (mem_req.ack) begin
            state <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          // Wait for ack low before the next vertex
          if (!mem_req.ack) begin
            if (next_vertex < {1'b0, descriptor.vertex_count}) begin
              vertex <= next_vertex[15:0];
              state  <= ST_REQ;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule : vertex_request_engine

`default_nettype wire

// File: sim.f
rtl/graph_types_pkg.sv
rtl/cache_types_pkg.sv
rtl/mem_req_if.sv
rtl/descriptor_dispatcher.sv
rtl/vertex_request_engine.sv
rtl/request_fifo.sv
rtl/cache_request_generator.sv
rtl/graph_fetch_top.sv
bench/clock_gen.sv
bench/tb_graph_fetch.sv
